// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_core
FLAGS ?= -j 0
OBJ_DIR ?= obj_dir

.PHONY: compile run clean

compile:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f sim.f

# the simulation passes only if its output holds the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'No errors'

clean:
	rm -rf $(OBJ_DIR)

// ==== core_top.sv ====
`timescale 1ns/1ps

module core_top (
	input logic clock,
	input logic reset,
	output isa_pkg::word_t im_addr,
	input isa_pkg::word_t instruction,
	output isa_pkg::word_t dm_addr,
	output isa_pkg::word_t dm_wdata,
	input isa_pkg::word_t dm_rdata,
	output logic dm_read,
	output logic dm_write
);

	ctrl_pkg::phase_t phase;
	isa_pkg::word_t pc;

	decode_if dec_bus ();

	phase_sequencer seq0 (
		.clock(clock),
		.reset(reset),
		.phase(phase)
	);

	instr_decoder dec0 (
		.clock(clock),
		.reset(reset),
		.phase(phase),
		.instruction(instruction),
		.dec(dec_bus.decoder)
	);

	execute_unit exu0 (
		.clock(clock),
		.reset(reset),
		.phase(phase),
		.dec(dec_bus.datapath),
		.pc(pc),
		.dm_addr(dm_addr),
		.dm_wdata(dm_wdata),
		.dm_rdata(dm_rdata),
		.dm_read(dm_read),
		.dm_write(dm_write)
	);

	// fetch address is the live program counter
	assign im_addr = pc;

endmodule

// ==== ctrl_pkg.sv ====
package ctrl_pkg;

	// second ALU operand
	typedef enum logic [2:0] {
		src2_rb,
		src2_imm,
		src2_lswi,
		src2_lsw,
		src2_benx,
		src2_none
	} alu_src2_t;

	// imm_15_ze doubles as the "unused" marker
	typedef enum logic [1:0] {
		imm_5_ze,
		imm_15_se,
		imm_15_ze,
		imm_20_se
	} imm_ext_t;

	typedef enum logic [1:0] {
		wr_alu,
		wr_imm,
		wr_mem,
		wr_none
	} wr_sel_t;

	// one-hot, exactly one bit set per cycle
	typedef struct packed {
		logic writeback;
		logic memaccess;
		logic execute;
		logic decode;
		logic fetch;
	} phase_t;

endpackage

// ==== decode_if.sv ====
`timescale 1ns/1ps

interface decode_if;

	isa_pkg::op_t opcode;
	logic [4:0] sub_op_base;
	logic [1:0] sub_op_sv;
	logic branch_ne;
	logic is_jump;

	isa_pkg::reg_addr_t ra_addr;
	isa_pkg::reg_addr_t rb_addr;
	isa_pkg::reg_addr_t rt_addr;

	logic [4:0] imm_5;
	logic [13:0] imm_14;
	logic [14:0] imm_15;
	logic [19:0] imm_20;
	logic [23:0] imm_24;

	ctrl_pkg::alu_src2_t select_alu_src2;
	ctrl_pkg::imm_ext_t select_imm_extend;
	ctrl_pkg::wr_sel_t select_write_reg;

	logic do_dm_read;
	logic do_dm_write;
	logic do_reg_write;

	modport decoder (
		output opcode, sub_op_base, sub_op_sv, branch_ne, is_jump,
		output ra_addr, rb_addr, rt_addr,
		output imm_5, imm_14, imm_15, imm_20, imm_24,
		output select_alu_src2, select_imm_extend, select_write_reg,
		output do_dm_read, do_dm_write, do_reg_write
	);

	modport datapath (
		input opcode, sub_op_base, sub_op_sv, branch_ne, is_jump,
		input ra_addr, rb_addr, rt_addr,
		input imm_5, imm_14, imm_15, imm_20, imm_24,
		input select_alu_src2, select_imm_extend, select_write_reg,
		input do_dm_read, do_dm_write, do_reg_write
	);

endinterface

// ==== execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
	input logic clock,
	input logic reset,
	input ctrl_pkg::phase_t phase,
	decode_if.datapath dec,
	output isa_pkg::word_t pc,
	output isa_pkg::word_t dm_addr,
	output isa_pkg::word_t dm_wdata,
	input isa_pkg::word_t dm_rdata,
	output logic dm_read,
	output logic dm_write
);

	isa_pkg::word_t ra_data, rb_data, rt_data;
	isa_pkg::word_t ra_q, rb_q, rt_q;
	isa_pkg::word_t alu_q, imm_q, mem_q;
	isa_pkg::word_t imm_ext, src2, alu_out, wb_data, pc_next;
	isa_pkg::word_t branch_off, jump_off;
	logic [63:0] rot_full;
	logic take_branch, take_q, reg_we;

	register_file rf0 (
		.clock(clock),
		.reset(reset),
		.ra_addr(dec.ra_addr),
		.rb_addr(dec.rb_addr),
		.rt_addr(dec.rt_addr),
		.ra_data(ra_data),
		.rb_data(rb_data),
		.rt_data(rt_data),
		.write_en(reg_we),
		.write_addr(dec.rt_addr),
		.write_data(wb_data)
	);

	always_comb begin
		case (dec.select_imm_extend)
			ctrl_pkg::imm_5_ze: imm_ext = {27'b0, dec.imm_5};
			ctrl_pkg::imm_15_se: imm_ext = {{17{dec.imm_15[14]}}, dec.imm_15};
			ctrl_pkg::imm_20_se: imm_ext = {{12{dec.imm_20[19]}}, dec.imm_20};
			default: imm_ext = {17'b0, dec.imm_15};
		endcase
	end

	always_comb begin
		case (dec.select_alu_src2)
			ctrl_pkg::src2_rb: src2 = rb_q;
			ctrl_pkg::src2_imm: src2 = imm_ext;
			// word offset, scaled by four
			ctrl_pkg::src2_lswi: src2 = {{15{dec.imm_15[14]}}, dec.imm_15, 2'b00};
			ctrl_pkg::src2_lsw: src2 = rb_q << dec.sub_op_sv;
			ctrl_pkg::src2_benx: src2 = rt_q;
			default: src2 = '0;
		endcase
	end

	assign rot_full = {ra_q, ra_q} >> src2[4:0];

	// loads, stores and addi all fall through to the adder
	always_comb begin
		alu_out = ra_q + src2;
		case (dec.opcode)
			isa_pkg::op_base: begin
				case (dec.sub_op_base)
					isa_pkg::sub_sub: alu_out = ra_q - src2;
					isa_pkg::sub_and: alu_out = ra_q & src2;
					isa_pkg::sub_or: alu_out = ra_q | src2;
					isa_pkg::sub_xor: alu_out = ra_q ^ src2;
					isa_pkg::sub_srli: alu_out = ra_q >> src2[4:0];
					isa_pkg::sub_slli: alu_out = ra_q << src2[4:0];
					isa_pkg::sub_rotri: alu_out = rot_full[31:0];
					default: alu_out = ra_q + src2;
				endcase
			end
			isa_pkg::op_ori: alu_out = ra_q | src2;
			isa_pkg::op_xori: alu_out = ra_q ^ src2;
			default: ;
		endcase
	end

	// beq on equal, bne on unequal
	assign take_branch = (dec.select_alu_src2 == ctrl_pkg::src2_benx) &&
		((ra_q == src2) != dec.branch_ne);

	always_ff @(posedge clock) begin
		if (phase.decode) begin
			ra_q <= ra_data;
			rb_q <= rb_data;
			rt_q <= rt_data;
		end
		if (phase.execute) begin
			alu_q <= alu_out;
			imm_q <= imm_ext;
		end
		if (phase.memaccess) begin
			mem_q <= dm_rdata;
		end
	end

	assign dm_addr = alu_q;
	assign dm_wdata = rt_q;
	assign dm_read = phase.memaccess & dec.do_dm_read;
	assign dm_write = phase.memaccess & dec.do_dm_write;

	always_comb begin
		case (dec.select_write_reg)
			ctrl_pkg::wr_imm: wb_data = imm_q;
			ctrl_pkg::wr_mem: wb_data = mem_q;
			default: wb_data = alu_q;
		endcase
	end

	assign reg_we = phase.writeback & dec.do_reg_write;

	// halfword-scaled offsets
	assign branch_off = {{17{dec.imm_14[13]}}, dec.imm_14, 1'b0};
	assign jump_off = {{7{dec.imm_24[23]}}, dec.imm_24, 1'b0};

	always_comb begin
		pc_next = pc + 32'd4;
		if (dec.is_jump) begin
			pc_next = pc + jump_off;
		end else if (take_q) begin
			pc_next = pc + branch_off;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= '0;
			take_q <= 1'b0;
		end else begin
			if (phase.execute) begin
				take_q <= take_branch;
			end
			if (phase.writeback) begin
				pc <= pc_next;
			end
		end
	end

endmodule

// ==== instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
	input logic clock,
	input logic reset,
	input ctrl_pkg::phase_t phase,
	input isa_pkg::word_t instruction,
	decode_if.decoder dec
);

	isa_pkg::word_t ir;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			ir <= '0;
		end else if (phase.fetch) begin
			ir <= instruction;
		end
	end

	// field split
	assign dec.opcode = isa_pkg::op_t'(ir[isa_pkg::op_msb:isa_pkg::op_lsb]);
	assign dec.sub_op_base = ir[isa_pkg::sub_base_msb:0];
	assign dec.sub_op_sv = ir[isa_pkg::sv_msb:isa_pkg::sv_lsb];
	assign dec.branch_ne = ir[isa_pkg::br_sense_bit];
	assign dec.is_jump = (dec.opcode == isa_pkg::op_j);

	assign dec.ra_addr = ir[isa_pkg::ra_msb:isa_pkg::ra_lsb];
	assign dec.rb_addr = ir[isa_pkg::rb_msb:isa_pkg::rb_lsb];
	assign dec.rt_addr = ir[isa_pkg::rt_msb:isa_pkg::rt_lsb];

	// 5-bit immediate shares the rb slot
	assign dec.imm_5 = ir[isa_pkg::rb_msb:isa_pkg::rb_lsb];
	assign dec.imm_14 = ir[13:0];
	assign dec.imm_15 = ir[14:0];
	assign dec.imm_20 = ir[19:0];
	assign dec.imm_24 = ir[23:0];

	always_comb begin
		dec.select_alu_src2 = ctrl_pkg::src2_none;
		dec.select_imm_extend = ctrl_pkg::imm_15_ze;
		dec.select_write_reg = ctrl_pkg::wr_none;
		dec.do_dm_read = 1'b0;
		dec.do_dm_write = 1'b0;
		dec.do_reg_write = 1'b0;
		case (dec.opcode)
			isa_pkg::op_base: begin
				case (dec.sub_op_base)
					isa_pkg::sub_add, isa_pkg::sub_sub, isa_pkg::sub_and,
					isa_pkg::sub_or, isa_pkg::sub_xor: begin
						dec.select_alu_src2 = ctrl_pkg::src2_rb;
						dec.select_write_reg = ctrl_pkg::wr_alu;
						dec.do_reg_write = 1'b1;
					end
					isa_pkg::sub_srli, isa_pkg::sub_slli, isa_pkg::sub_rotri: begin
						dec.select_alu_src2 = ctrl_pkg::src2_imm;
						dec.select_imm_extend = ctrl_pkg::imm_5_ze;
						dec.select_write_reg = ctrl_pkg::wr_alu;
						dec.do_reg_write = 1'b1;
					end
					default: ;
				endcase
			end
			isa_pkg::op_addi: begin
				dec.select_alu_src2 = ctrl_pkg::src2_imm;
				dec.select_imm_extend = ctrl_pkg::imm_15_se;
				dec.select_write_reg = ctrl_pkg::wr_alu;
				dec.do_reg_write = 1'b1;
			end
			isa_pkg::op_ori, isa_pkg::op_xori: begin
				dec.select_alu_src2 = ctrl_pkg::src2_imm;
				dec.select_write_reg = ctrl_pkg::wr_alu;
				dec.do_reg_write = 1'b1;
			end
			isa_pkg::op_movi: begin
				dec.select_imm_extend = ctrl_pkg::imm_20_se;
				dec.select_write_reg = ctrl_pkg::wr_imm;
				dec.do_reg_write = 1'b1;
			end
			isa_pkg::op_lwi: begin
				dec.select_alu_src2 = ctrl_pkg::src2_lswi;
				dec.select_write_reg = ctrl_pkg::wr_mem;
				dec.do_dm_read = 1'b1;
				dec.do_reg_write = 1'b1;
			end
			isa_pkg::op_swi: begin
				dec.select_alu_src2 = ctrl_pkg::src2_lswi;
				dec.do_dm_write = 1'b1;
			end
			isa_pkg::op_ls: begin
				if (ir[isa_pkg::sub_ls_msb:0] == isa_pkg::sub_lw) begin
					dec.select_alu_src2 = ctrl_pkg::src2_lsw;
					dec.select_write_reg = ctrl_pkg::wr_mem;
					dec.do_dm_read = 1'b1;
					dec.do_reg_write = 1'b1;
				end else if (ir[isa_pkg::sub_ls_msb:0] == isa_pkg::sub_sw) begin
					dec.select_alu_src2 = ctrl_pkg::src2_lsw;
					dec.do_dm_write = 1'b1;
				end
			end
			isa_pkg::op_b: dec.select_alu_src2 = ctrl_pkg::src2_benx;
			// j and undefined opcodes keep every write off
			default: ;
		endcase
	end

endmodule

// ==== isa_pkg.sv ====
package isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	localparam int num_regs = 32;

	// major opcodes, instruction bits 30:25
	typedef enum logic [5:0] {
		op_lwi  = 6'b000010,
		op_swi  = 6'b001010,
		op_ls   = 6'b011100,
		op_base = 6'b100000,
		op_movi = 6'b100010,
		op_j    = 6'b100100,
		op_b    = 6'b100110,
		op_addi = 6'b101000,
		op_xori = 6'b101011,
		op_ori  = 6'b101100
	} op_t;

	// base group sub-opcodes, bits 4:0
	localparam logic [4:0] sub_add   = 5'b00000;
	localparam logic [4:0] sub_sub   = 5'b00001;
	localparam logic [4:0] sub_and   = 5'b00010;
	localparam logic [4:0] sub_xor   = 5'b00011;
	localparam logic [4:0] sub_or    = 5'b00100;
	localparam logic [4:0] sub_slli  = 5'b01000;
	localparam logic [4:0] sub_srli  = 5'b01001;
	localparam logic [4:0] sub_rotri = 5'b01011;

	// load/store group sub-opcodes, bits 7:0
	localparam logic [7:0] sub_lw = 8'b00000010;
	localparam logic [7:0] sub_sw = 8'b00001010;

	// field positions
	localparam int op_msb = 30;
	localparam int op_lsb = 25;
	localparam int rt_msb = 24;
	localparam int rt_lsb = 20;
	localparam int ra_msb = 19;
	localparam int ra_lsb = 15;
	localparam int rb_msb = 14;
	localparam int rb_lsb = 10;
	localparam int sv_msb = 9;
	localparam int sv_lsb = 8;
	localparam int sub_base_msb = 4;
	localparam int sub_ls_msb = 7;
	localparam int br_sense_bit = 14;

endpackage

// ==== phase_sequencer.sv ====
`timescale 1ns/1ps

module phase_sequencer (
	input logic clock,
	input logic reset,
	output ctrl_pkg::phase_t phase
);

	typedef enum logic [2:0] {
		st_fetch,
		st_decode,
		st_execute,
		st_memaccess,
		st_writeback
	} state_t;

	state_t state;
	state_t state_next;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= st_fetch;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		phase = '0;
		state_next = st_fetch;
		case (state)
			st_fetch: begin
				phase.fetch = 1'b1;
				state_next = st_decode;
			end
			st_decode: begin
				phase.decode = 1'b1;
				state_next = st_execute;
			end
			st_execute: begin
				phase.execute = 1'b1;
				state_next = st_memaccess;
			end
			st_memaccess: begin
				phase.memaccess = 1'b1;
				state_next = st_writeback;
			end
			st_writeback: begin
				phase.writeback = 1'b1;
				state_next = st_fetch;
			end
			// illegal codes, no enable, back to fetch
			default: state_next = st_fetch;
		endcase
	end

endmodule

// ==== register_file.sv ====
`timescale 1ns/1ps

module register_file (
	input logic clock,
	input logic reset,
	input isa_pkg::reg_addr_t ra_addr,
	input isa_pkg::reg_addr_t rb_addr,
	input isa_pkg::reg_addr_t rt_addr,
	output isa_pkg::word_t ra_data,
	output isa_pkg::word_t rb_data,
	output isa_pkg::word_t rt_data,
	input logic write_en,
	input isa_pkg::reg_addr_t write_addr,
	input isa_pkg::word_t write_data
);

	isa_pkg::word_t regs [isa_pkg::num_regs];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < isa_pkg::num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en && write_addr != '0) begin
			regs[write_addr] <= write_data;
		end
	end

	// r0 is hardwired to zero
	assign ra_data = (ra_addr == '0) ? '0 : regs[ra_addr];
	assign rb_data = (rb_addr == '0) ? '0 : regs[rb_addr];
	assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

// ==== sim.f ====
isa_pkg.sv
ctrl_pkg.sv
decode_if.sv
phase_sequencer.sv
instr_decoder.sv
register_file.sv
execute_unit.sv
core_top.sv
tb_core.sv

// ==== tb_core.sv ====
`timescale 1ns/1ps

module tb_core;

	logic clock;
	logic reset;
	isa_pkg::word_t im_addr;
	isa_pkg::word_t instruction;
	isa_pkg::word_t dm_addr;
	isa_pkg::word_t dm_wdata;
	isa_pkg::word_t dm_rdata;
	logic dm_read;
	logic dm_write;

	isa_pkg::word_t imem [256];
	isa_pkg::word_t dmem [256];
	isa_pkg::word_t prog [$];
	isa_pkg::word_t store_addr_q [$];
	isa_pkg::word_t store_data_q [$];
	isa_pkg::word_t read_addr_q [$];
	int mismatches;
	int failures;

	core_top dut0 (
		.clock(clock),
		.reset(reset),
		.im_addr(im_addr),
		.instruction(instruction),
		.dm_addr(dm_addr),
		.dm_wdata(dm_wdata),
		.dm_rdata(dm_rdata),
		.dm_read(dm_read),
		.dm_write(dm_write)
	);

	always #50 clock = ~clock;

	// both memories answer in the same cycle
	assign instruction = imem[im_addr[9:2]];
	assign dm_rdata = dm_read ? dmem[dm_addr[9:2]] : '0;

	// DUT outputs are settled by mid-cycle
	always @(negedge clock) begin
		if (reset) begin
			store_addr_q.delete();
			store_data_q.delete();
			read_addr_q.delete();
			for (int i = 0; i < 256; i++) begin
				dmem[i] = {16'hdead, 16'(i)};
			end
		end else begin
			if (dm_write) begin
				store_addr_q.push_back(dm_addr);
				store_data_q.push_back(dm_wdata);
				dmem[dm_addr[9:2]] = dm_wdata;
			end
			if (dm_read) begin
				read_addr_q.push_back(dm_addr);
			end
		end
	end

	function automatic isa_pkg::word_t rr_instr(logic [4:0] sub, isa_pkg::reg_addr_t rt,
		isa_pkg::reg_addr_t ra, isa_pkg::reg_addr_t rb);
		return {1'b0, isa_pkg::op_base, rt, ra, rb, 5'b0, sub};
	endfunction

	function automatic isa_pkg::word_t imm_instr(logic [5:0] op, isa_pkg::reg_addr_t rt,
		isa_pkg::reg_addr_t ra, logic [14:0] imm);
		return {1'b0, op, rt, ra, imm};
	endfunction

	function automatic isa_pkg::word_t movi_instr(isa_pkg::reg_addr_t rt, logic [19:0] imm);
		return {1'b0, isa_pkg::op_movi, rt, imm};
	endfunction

	function automatic isa_pkg::word_t ls_instr(logic [7:0] sub, isa_pkg::reg_addr_t rt,
		isa_pkg::reg_addr_t ra, isa_pkg::reg_addr_t rb, logic [1:0] sv);
		return {1'b0, isa_pkg::op_ls, rt, ra, rb, sv, sub};
	endfunction

	// offsets count halfwords
	function automatic isa_pkg::word_t branch_instr(logic ne, isa_pkg::reg_addr_t rt,
		isa_pkg::reg_addr_t ra, logic [13:0] off);
		return {1'b0, isa_pkg::op_b, rt, ra, ne, off};
	endfunction

	function automatic isa_pkg::word_t jump_instr(logic [23:0] off);
		return {1'b0, isa_pkg::op_j, 1'b0, off};
	endfunction

	task automatic check_word(string name, isa_pkg::word_t got, isa_pkg::word_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_pc(string name, isa_pkg::word_t got, isa_pkg::word_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s is 0x%h, expected 0x%h", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic expect_store(int i, isa_pkg::word_t addr, isa_pkg::word_t data);
		if (i >= store_addr_q.size()) begin
			$display("Error: store %0d never reached data memory", i);
			failures++;
		end else begin
			check_pc($sformatf("dm_addr[store %0d]", i), store_addr_q[i], addr);
			check_word($sformatf("dm_wdata[store %0d]", i), store_data_q[i], data);
		end
	endtask

	task automatic wait_stores(int n, int limit);
		int cycles;
		cycles = 0;
		while (store_addr_q.size() < n && cycles < limit) begin
			@(posedge clock);
			cycles++;
		end
		if (store_addr_q.size() < n) begin
			$display("Timeout: %0d of %0d stores seen after %0d cycles",
				store_addr_q.size(), n, cycles);
			failures++;
		end
	endtask

	// reset held while the program is loaded
	task automatic start_program();
		@(posedge clock);
		#1 reset = 1'b1;
		for (int i = 0; i < 256; i++) begin
			imem[i] = (i < prog.size()) ? prog[i] : '0;
		end
		repeat (4) @(posedge clock);
		#1 reset = 1'b0;
	endtask

	task automatic test_reset_timing();
		logic [19:0] r20;
		r20 = 20'($urandom());
		prog.delete();
		prog.push_back(movi_instr(5'd1, r20));
		prog.push_back(imm_instr(isa_pkg::op_swi, 5'd1, 5'd0, 15'd4));
		prog.push_back(jump_instr(24'd0));
		start_program();
		for (int k = 0; k < 15; k++) begin
			@(negedge clock);
			check_pc($sformatf("im_addr cycle %0d", k), im_addr, 32'(4 * (k / 5)));
			check_bit("dm_read", dm_read, 1'b0);
			check_bit($sformatf("dm_write cycle %0d", k), dm_write, k == 8);
		end
		expect_store(0, 32'd16, {{12{r20[19]}}, r20});
	endtask

	task automatic test_alu();
		logic [19:0] ra20;
		logic [19:0] rb20;
		isa_pkg::word_t a;
		isa_pkg::word_t b;
		ra20 = 20'($urandom());
		rb20 = 20'($urandom());
		a = {{12{ra20[19]}}, ra20};
		b = {{12{rb20[19]}}, rb20};
		prog.delete();
		prog.push_back(movi_instr(5'd1, ra20));
		prog.push_back(movi_instr(5'd2, rb20));
		prog.push_back(rr_instr(isa_pkg::sub_add, 5'd3, 5'd1, 5'd2));
		prog.push_back(rr_instr(isa_pkg::sub_sub, 5'd4, 5'd1, 5'd2));
		prog.push_back(rr_instr(isa_pkg::sub_and, 5'd5, 5'd1, 5'd2));
		prog.push_back(rr_instr(isa_pkg::sub_or, 5'd6, 5'd1, 5'd2));
		prog.push_back(rr_instr(isa_pkg::sub_xor, 5'd7, 5'd1, 5'd2));
		for (int i = 0; i < 5; i++) begin
			prog.push_back(imm_instr(isa_pkg::op_swi, 5'(3 + i), 5'd0, 15'(i)));
		end
		prog.push_back(jump_instr(24'd0));
		start_program();
		wait_stores(5, 150);
		expect_store(0, 32'd0, a + b);
		expect_store(1, 32'd4, a - b);
		expect_store(2, 32'd8, a & b);
		expect_store(3, 32'd12, a | b);
		expect_store(4, 32'd16, a ^ b);
	endtask

	task automatic test_immediates();
		logic [19:0] v20;
		logic [19:0] m20;
		logic [14:0] add15;
		logic [14:0] or15;
		logic [14:0] xor15;
		logic [4:0] s1;
		logic [4:0] s2;
		logic [4:0] s3;
		isa_pkg::word_t v;
		v20 = 20'($urandom());
		m20 = {1'b1, 19'($urandom())};
		add15 = {1'b1, 14'($urandom())};
		or15 = {1'b1, 14'($urandom())};
		xor15 = {1'b1, 14'($urandom())};
		s1 = 5'($urandom_range(31, 1));
		s2 = 5'($urandom_range(31, 1));
		s3 = 5'($urandom_range(31, 1));
		v = {{12{v20[19]}}, v20};
		prog.delete();
		prog.push_back(movi_instr(5'd1, v20));
		prog.push_back(imm_instr(isa_pkg::op_addi, 5'd2, 5'd1, add15));
		prog.push_back(imm_instr(isa_pkg::op_ori, 5'd3, 5'd1, or15));
		prog.push_back(imm_instr(isa_pkg::op_xori, 5'd4, 5'd1, xor15));
		prog.push_back(rr_instr(isa_pkg::sub_srli, 5'd5, 5'd1, s1));
		prog.push_back(rr_instr(isa_pkg::sub_slli, 5'd6, 5'd1, s2));
		prog.push_back(rr_instr(isa_pkg::sub_rotri, 5'd7, 5'd1, s3));
		prog.push_back(movi_instr(5'd8, m20));
		for (int i = 0; i < 7; i++) begin
			prog.push_back(imm_instr(isa_pkg::op_swi, 5'(2 + i), 5'd0, 15'(i)));
		end
		prog.push_back(jump_instr(24'd0));
		start_program();
		wait_stores(7, 200);
		expect_store(0, 32'd0, v + {{17{add15[14]}}, add15});
		expect_store(1, 32'd4, v | {17'b0, or15});
		expect_store(2, 32'd8, v ^ {17'b0, xor15});
		expect_store(3, 32'd12, v >> s1);
		expect_store(4, 32'd16, v << s2);
		expect_store(5, 32'd20, (v >> s3) | (v << (32 - s3)));
		expect_store(6, 32'd24, {{12{m20[19]}}, m20});
	endtask

	task automatic test_load_store();
		logic [19:0] d1_20;
		logic [19:0] d2_20;
		isa_pkg::word_t d1;
		isa_pkg::word_t d2;
		isa_pkg::word_t reads [3];
		d1_20 = 20'($urandom());
		d2_20 = 20'($urandom());
		d1 = {{12{d1_20[19]}}, d1_20};
		d2 = {{12{d2_20[19]}}, d2_20};
		reads = '{32'd72, 32'd76, 32'd88};
		prog.delete();
		prog.push_back(movi_instr(5'd1, 20'd64));
		prog.push_back(movi_instr(5'd2, d1_20));
		prog.push_back(movi_instr(5'd3, 20'd3));
		prog.push_back(imm_instr(isa_pkg::op_swi, 5'd2, 5'd1, 15'd2));
		prog.push_back(imm_instr(isa_pkg::op_lwi, 5'd4, 5'd1, 15'd2));
		prog.push_back(ls_instr(isa_pkg::sub_sw, 5'd4, 5'd1, 5'd3, 2'd2));
		prog.push_back(ls_instr(isa_pkg::sub_lw, 5'd5, 5'd1, 5'd3, 2'd2));
		prog.push_back(movi_instr(5'd6, d2_20));
		prog.push_back(ls_instr(isa_pkg::sub_sw, 5'd6, 5'd1, 5'd3, 2'd3));
		prog.push_back(imm_instr(isa_pkg::op_lwi, 5'd7, 5'd1, 15'd6));
		prog.push_back(imm_instr(isa_pkg::op_swi, 5'd5, 5'd0, 15'd0));
		prog.push_back(imm_instr(isa_pkg::op_swi, 5'd7, 5'd0, 15'd1));
		prog.push_back(jump_instr(24'd0));
		start_program();
		wait_stores(5, 200);
		expect_store(0, 32'd72, d1);
		expect_store(1, 32'd76, d1);
		expect_store(2, 32'd88, d2);
		expect_store(3, 32'd0, d1);
		expect_store(4, 32'd4, d2);
		if (read_addr_q.size() != 3) begin
			$display("Error: dm_read raised in %0d cycles, expected 3", read_addr_q.size());
			failures++;
		end else begin
			for (int i = 0; i < 3; i++) begin
				check_pc($sformatf("dm_addr[read %0d]", i), read_addr_q[i], reads[i]);
			end
		end
	endtask

	task automatic test_control_flow();
		isa_pkg::word_t seq [13];
		seq = '{32'd0, 32'd4, 32'd8, 32'd12, 32'd24, 32'd32, 32'd36,
			32'd40, 32'd52, 32'd56, 32'd44, 32'd48, 32'd48};
		prog.delete();
		prog.push_back(movi_instr(5'd1, 20'd5));
		prog.push_back(movi_instr(5'd2, 20'd5));
		prog.push_back(movi_instr(5'd3, 20'd7));
		// beq taken over two stores
		prog.push_back(branch_instr(1'b0, 5'd1, 5'd2, 14'd6));
		prog.push_back(imm_instr(isa_pkg::op_swi, 5'd1, 5'd0, 15'd0));
		prog.push_back(imm_instr(isa_pkg::op_swi, 5'd1, 5'd0, 15'd1));
		prog.push_back(branch_instr(1'b1, 5'd1, 5'd3, 14'd4));
		prog.push_back(imm_instr(isa_pkg::op_swi, 5'd1, 5'd0, 15'd2));
		prog.push_back(branch_instr(1'b0, 5'd1, 5'd3, 14'd4));
		prog.push_back(branch_instr(1'b1, 5'd1, 5'd2, 14'd4));
		prog.push_back(jump_instr(24'd6));
		prog.push_back(imm_instr(isa_pkg::op_swi, 5'd3, 5'd0, 15'd3));
		prog.push_back(jump_instr(24'd0));
		prog.push_back(imm_instr(isa_pkg::op_swi, 5'd2, 5'd0, 15'd4));
		// back by twelve bytes
		prog.push_back(jump_instr(24'hfffffa));
		start_program();
		for (int k = 0; k < 65; k++) begin
			@(negedge clock);
			check_pc($sformatf("im_addr cycle %0d", k), im_addr, seq[k / 5]);
		end
		if (store_addr_q.size() != 2) begin
			$display("Error: %0d stores seen, expected 2", store_addr_q.size());
			failures++;
		end
		expect_store(0, 32'd16, 32'd5);
		expect_store(1, 32'd12, 32'd7);
	endtask

	task automatic test_undefined();
		logic [19:0] v20;
		v20 = {1'b1, 19'($urandom())};
		prog.delete();
		prog.push_back(movi_instr(5'd1, v20));
		// operands from r0 so a stray write would change r1
		prog.push_back(rr_instr(5'b11111, 5'd1, 5'd0, 5'd0));
		prog.push_back(imm_instr(6'b111111, 5'd1, 5'd0, 15'h7fff));
		prog.push_back(ls_instr(8'hff, 5'd1, 5'd0, 5'd0, 2'd0));
		prog.push_back(movi_instr(5'd0, 20'h12345));
		prog.push_back(rr_instr(isa_pkg::sub_add, 5'd0, 5'd1, 5'd1));
		prog.push_back(imm_instr(isa_pkg::op_swi, 5'd1, 5'd0, 15'd0));
		prog.push_back(imm_instr(isa_pkg::op_swi, 5'd0, 5'd0, 15'd1));
		prog.push_back(jump_instr(24'd0));
		start_program();
		wait_stores(2, 150);
		expect_store(0, 32'd0, {{12{v20[19]}}, v20});
		expect_store(1, 32'd4, 32'd0);
		if (read_addr_q.size() != 0) begin
			$display("Error: dm_read raised in %0d cycles with no load", read_addr_q.size());
			failures++;
		end
	endtask

	initial begin
		int seed_ret;
		clock = 1'b0;
		reset = 1'b1;
		mismatches = 0;
		failures = 0;
		for (int i = 0; i < 256; i++) begin
			imem[i] = '0;
		end
		seed_ret = $urandom(70);
		test_reset_timing();
		test_alu();
		test_immediates();
		test_load_store();
		test_control_flow();
		test_undefined();
		$display("Summary: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule
